// File: src/bridge_pkg.sv
package bridge_pkg;

  ////////////////////
  // widths
  ////////////////////

  // uart and spi bytes
  localparam int BYTE_W = 8;
  // address byte then data byte
  localparam int SPI_FRAME_W = 16;

  ////////////////////
  // timing
  ////////////////////

  // sys_clk cycles per sck half period
  localparam int SPI_HALF_PERIOD = 4;
  // 115200 baud at 100 MHz
  localparam int DEFAULT_CLKS_PER_BIT = 868;
  localparam int REPLY_FIFO_DEPTH = 4;
  // display reset hold after system reset
  localparam int RESET_HOLD_CYCLES = 10;

  ////////////////////
  // state encodings
  ////////////////////

  // bit phase, shared by rx and tx
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_e;

endpackage

// File: src/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch import bridge_pkg::*; (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  // wide enough to hold the full count
  localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt_q;

  // count reloads for as long as reset is high
  // display reset released only once count hits zero
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q    <= CNT_W'(RESET_HOLD_CYCLES);
      slm_reset_n_o <= 1'b0;
    end else begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      // active low toward the display
      slm_reset_n_o <= (hold_cnt_q == '0);
    end
  end

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT
) (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_serial_i,
  output logic              rx_valid_o,
  output logic [BYTE_W-1:0] rx_byte_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(BYTE_W);
  // end of a full bit, and the middle of the start bit
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  logic             rx_meta_q;
  logic             rx_sync_q;
  uart_state_e      state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [IDX_W-1:0] bit_idx_q;
  logic             sample_data;

  ////////////////////
  // line sync
  ////////////////////

  // two flops, line idles high
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  ////////////////////
  // bit phase fsm
  ////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= UART_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          // falling edge opens a frame
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt_q == HALF_LAST) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            // still low at mid bit, otherwise a glitch
            state_q   <= rx_sync_q ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == IDX_W'(BYTE_W - 1)) begin
              state_q <= UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            // low stop bit means framing error, byte dropped
            rx_valid_o <= rx_sync_q;
            state_q    <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // mid bit of each data bit
  assign sample_data = (state_q == UART_DATA) && (clk_cnt_q == BIT_LAST);

  // lsb arrives first, shift in from the top
  always_ff @(posedge sys_clk) begin
    if (sample_data) begin
      rx_byte_o <= {rx_sync_q, rx_byte_o[BYTE_W-1:1]};
    end
  end

endmodule

// File: src/cmd_pairer.sv
`timescale 1ns/1ps

module cmd_pairer import bridge_pkg::*; (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   rx_valid_i,
  input  logic [BYTE_W-1:0]      rx_byte_i,
  output logic                   spi_start_o,
  output logic [SPI_FRAME_W-1:0] spi_word_o
);

  // set once the address byte of a pair is held
  logic              have_addr_q;
  logic [BYTE_W-1:0] addr_q;
  logic              pair_done;

  // second byte of a pair completes the command
  assign pair_done = rx_valid_i && have_addr_q;

  ////////////////////
  // odd/even tracking
  ////////////////////

  // reset puts us back at an address byte
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      have_addr_q <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= pair_done;
      if (rx_valid_i) begin
        have_addr_q <= !have_addr_q;
      end
    end
  end

  ////////////////////
  // byte capture
  ////////////////////

  // first byte parks here
  always_ff @(posedge sys_clk) begin
    if (rx_valid_i && !have_addr_q) begin
      addr_q <= rx_byte_i;
    end
  end

  // address goes out first, so upper half
  always_ff @(posedge sys_clk) begin
    if (pair_done) begin
      spi_word_o <= {addr_q, rx_byte_i};
    end
  end

endmodule

// File: src/spi_master.sv
`timescale 1ns/1ps

module spi_master import bridge_pkg::*; (
  input  logic                   sys_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   spi_start_i,
  input  logic [SPI_FRAME_W-1:0] spi_word_i,
  output logic                   spi_sen_o,
  output logic                   spi_sck_o,
  output logic                   spi_sdat_o,
  input  logic                   spi_sout_i,
  output logic                   spi_done_o,
  output logic [BYTE_W-1:0]      spi_reply_o
);

  localparam int HALF_W = (SPI_HALF_PERIOD > 1) ? $clog2(SPI_HALF_PERIOD) : 1;
  localparam int BIT_W  = $clog2(SPI_FRAME_W);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SPI_HALF_PERIOD - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(SPI_FRAME_W - 1);

  spi_state_e             state_q;
  logic [HALF_W-1:0]      half_cnt_q;
  logic [BIT_W-1:0]       bit_cnt_q;
  logic [SPI_FRAME_W-1:0] tx_sh_q;
  logic [BYTE_W-1:0]      rx_sh_q;
  logic                   half_end;
  logic                   sck_rise;

  assign half_end = (state_q == SPI_SHIFT) && (half_cnt_q == HALF_LAST);
  // sample point, mode 0
  assign sck_rise = half_end && !spi_sck_o;

  // msb first
  assign spi_sdat_o  = tx_sh_q[SPI_FRAME_W-1];
  assign spi_reply_o = rx_sh_q;

  ////////////////////
  // frame fsm
  ////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      spi_sen_o  <= 1'b1;
      spi_sck_o  <= 1'b0;
      spi_done_o <= 1'b0;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_sh_q    <= '0;
    end else begin
      spi_done_o <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          if (spi_start_i) begin
            // first bit valid as soon as select drops
            tx_sh_q    <= spi_word_i;
            spi_sen_o  <= 1'b0;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_cnt_q == HALF_LAST) begin
            half_cnt_q <= '0;
            spi_sck_o  <= !spi_sck_o;
            // falling edge ends a bit
            if (spi_sck_o) begin
              if (bit_cnt_q == BIT_LAST) begin
                spi_sen_o  <= 1'b1;
                spi_done_o <= 1'b1;
                state_q    <= SPI_FINISH;
              end else begin
                tx_sh_q   <= {tx_sh_q[SPI_FRAME_W-2:0], 1'b0};
                bit_cnt_q <= bit_cnt_q + 1'b1;
              end
            end
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
        // done cycle, select already high
        SPI_FINISH: state_q <= SPI_IDLE;
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // only the data half survives in the reply
  always_ff @(posedge sys_clk) begin
    if (sck_rise) begin
      rx_sh_q <= {rx_sh_q[BYTE_W-2:0], spi_sout_i};
    end
  end

  // pairer relies on a uart byte being far slower than a frame
  a_start_when_idle : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    spi_start_i |-> (state_q == SPI_IDLE)
  ) else $error("spi start while frame in progress");

endmodule

// File: src/reply_fifo.sv
`timescale 1ns/1ps

module reply_fifo import bridge_pkg::*; (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              push_i,
  input  logic [BYTE_W-1:0] push_data_i,
  input  logic              pop_i,
  output logic              empty_o,
  output logic [BYTE_W-1:0] head_o
);

  localparam int PTR_W = $clog2(REPLY_FIFO_DEPTH);
  localparam int CNT_W = $clog2(REPLY_FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(REPLY_FIFO_DEPTH - 1);

  logic [BYTE_W-1:0] mem_q [REPLY_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign full    = (count_q == CNT_W'(REPLY_FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  // reply dropped when full
  assign do_push = push_i && !full;
  assign do_pop  = pop_i && !empty_o;
  // show-ahead read
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge sys_clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  ////////////////////
  // pointers and count
  ////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // tx side must check empty before popping
  a_no_pop_empty : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    pop_i |-> !empty_o
  ) else $error("pop from empty reply fifo");

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT
) (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              fifo_empty_i,
  input  logic [BYTE_W-1:0] fifo_head_i,
  output logic              fifo_pop_o,
  output logic              tx_serial_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(BYTE_W);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  uart_state_e       state_q;
  logic [CNT_W-1:0]  clk_cnt_q;
  logic [IDX_W-1:0]  bit_idx_q;
  logic [BYTE_W-1:0] tx_sh_q;
  logic              load;
  logic              shift_en;

  // pop cycle, head still valid until this edge
  assign load     = (state_q == UART_IDLE) && fifo_pop_o;
  assign shift_en = (clk_cnt_q == BIT_LAST) &&
                    ((state_q == UART_START) || (state_q == UART_DATA));

  ////////////////////
  // bit phase fsm
  ////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= UART_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      fifo_pop_o  <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      fifo_pop_o <= 1'b0;
      if (state_q != UART_IDLE) begin
        clk_cnt_q <= (clk_cnt_q == BIT_LAST) ? '0 : clk_cnt_q + 1'b1;
      end
      case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (fifo_pop_o) begin
            // byte latched, start bit goes out
            tx_serial_o <= 1'b0;
            state_q     <= UART_START;
          end else if (!fifo_empty_i) begin
            fifo_pop_o <= 1'b1;
          end
        end
        UART_START: begin
          if (clk_cnt_q == BIT_LAST) begin
            tx_serial_o <= tx_sh_q[0];
            state_q     <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == BIT_LAST) begin
            if (bit_idx_q == IDX_W'(BYTE_W - 1)) begin
              tx_serial_o <= 1'b1;
              state_q     <= UART_STOP;
            end else begin
              // shift register already moved on
              tx_serial_o <= tx_sh_q[0];
              bit_idx_q   <= bit_idx_q + 1'b1;
            end
          end
        end
        UART_STOP: begin
          if (clk_cnt_q == BIT_LAST) begin
            state_q <= UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // lsb first, shift down
  always_ff @(posedge sys_clk) begin
    if (load) begin
      tx_sh_q <= fifo_head_i;
    end else if (shift_en) begin
      tx_sh_q <= tx_sh_q >> 1;
    end
  end

endmodule

// File: src/spi_bridge_top.sv
`timescale 1ns/1ps

module spi_bridge_top import bridge_pkg::*; #(
  parameter int CLKS_PER_BIT = DEFAULT_CLKS_PER_BIT
) (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i,
  output logic slm_reset_n_o
);

  // rx to pairer
  logic                   rx_valid;
  logic [BYTE_W-1:0]      rx_byte;
  // pairer to spi
  logic                   spi_start;
  logic [SPI_FRAME_W-1:0] spi_word;
  // spi to fifo
  logic                   spi_done;
  logic [BYTE_W-1:0]      spi_reply;
  // fifo to tx
  logic                   fifo_empty;
  logic [BYTE_W-1:0]      fifo_head;
  logic                   fifo_pop;

  ////////////////////
  // display reset
  ////////////////////

  reset_stretch u_reset_stretch (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  ////////////////////
  // host to display
  ////////////////////

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  // addr byte then data byte
  cmd_pairer u_cmd_pairer (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  spi_master u_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_word_i      (spi_word),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .spi_sout_i      (spi_sout_i),
    .spi_done_o      (spi_done),
    .spi_reply_o     (spi_reply)
  );

  ////////////////////
  // replies back to host
  ////////////////////

  reply_fifo u_reply_fifo (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .push_i          (spi_done),
    .push_data_i     (spi_reply),
    .pop_i           (fifo_pop),
    .empty_o         (fifo_empty),
    .head_o          (fifo_head)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .fifo_empty_i    (fifo_empty),
    .fifo_head_i     (fifo_head),
    .fifo_pop_o      (fifo_pop),
    .tx_serial_o     (uart_tx_o)
  );

endmodule

// File: tests/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model import bridge_pkg::*; (
  input  logic spi_sen_i,
  input  logic spi_sck_i,
  input  logic spi_sdat_i,
  output logic spi_sout_o
);

  // every complete frame, oldest first
  logic [SPI_FRAME_W-1:0] frame_q [$];
  int                     frame_count;
  logic [SPI_FRAME_W-1:0] shift_q;
  logic [BYTE_W-1:0]      reply_q;
  int                     bit_cnt;

  initial begin
    frame_count = 0;
    bit_cnt     = 0;
    shift_q     = '0;
    reply_q     = '0;
    spi_sout_o  = 1'b0;
  end

  ////////////////////
  // frame capture
  ////////////////////

  // select low opens a new frame
  always @(negedge spi_sen_i) begin
    bit_cnt    = 0;
    shift_q    = '0;
    spi_sout_o = 1'b0;
  end

  // mode 0, sample on the rising clock
  always @(posedge spi_sck_i) begin
    if (!spi_sen_i) begin
      shift_q = {shift_q[SPI_FRAME_W-2:0], spi_sdat_i};
      bit_cnt++;
      // address byte complete, answer with its inverse
      if (bit_cnt == BYTE_W) begin
        reply_q    = ~shift_q[BYTE_W-1:0];
        spi_sout_o = reply_q[BYTE_W-1];
      end
    end
  end

  // next reply bit while the clock is low
  always @(negedge spi_sck_i) begin
    if (!spi_sen_i && bit_cnt > BYTE_W && bit_cnt < SPI_FRAME_W) begin
      reply_q    = reply_q << 1;
      spi_sout_o = reply_q[BYTE_W-1];
    end
  end

  // only full frames are recorded
  always @(posedge spi_sen_i) begin
    if (bit_cnt == SPI_FRAME_W) begin
      frame_q.push_back(shift_q);
      frame_count++;
    end
    bit_cnt = 0;
  end

endmodule

// File: tests/tb_spi_bridge.sv
`timescale 1ns/1ps

module tb_spi_bridge import bridge_pkg::*; ();

  // fast uart so the run stays short
  localparam int BIT_CLKS     = 16;
  localparam int BYTE_CLKS    = 10 * BIT_CLKS;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 8 * BYTE_CLKS;

  logic   sys_clk;
  logic   reset_all_cmd_w;
  logic   uart_rx_line;
  logic   uart_tx_line;
  logic   spi_sen;
  logic   spi_sck;
  logic   spi_sdat;
  logic   spi_sout;
  logic   slm_reset_n;
  integer seed;

  spi_bridge_top #(.CLKS_PER_BIT(BIT_CLKS)) u_spi_bridge_top (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_line),
    .uart_tx_o       (uart_tx_line),
    .spi_sen_o       (spi_sen),
    .spi_sck_o       (spi_sck),
    .spi_sdat_o      (spi_sdat),
    .spi_sout_i      (spi_sout),
    .slm_reset_n_o   (slm_reset_n)
  );

  spi_slave_model u_spi_slave_model (
    .spi_sen_i  (spi_sen),
    .spi_sck_i  (spi_sck),
    .spi_sdat_i (spi_sdat),
    .spi_sout_o (spi_sout)
  );

  // 125 MHz
  initial sys_clk = 1'b0;
  always #4 sys_clk = ~sys_clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_with_error($sformatf("MISMATCH at %0t ns: %s", $time, what));
  endtask

  task automatic apply_reset();
    @(posedge sys_clk);
    reset_all_cmd_w <= 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    reset_all_cmd_w <= 1'b0;
  endtask

  // start, 8 data bits lsb first, stop
  task automatic uart_send_byte(input logic [BYTE_W-1:0] data);
    int i;
    @(posedge sys_clk);
    uart_rx_line <= 1'b0;
    repeat (BIT_CLKS) @(posedge sys_clk);
    for (i = 0; i < BYTE_W; i++) begin
      uart_rx_line <= data[i];
      repeat (BIT_CLKS) @(posedge sys_clk);
    end
    uart_rx_line <= 1'b1;
    repeat (BIT_CLKS) @(posedge sys_clk);
  endtask

  // must be waiting before the start bit falls
  task automatic uart_expect_byte(input logic [BYTE_W-1:0] expected);
    int                waited;
    bit                seen;
    int                i;
    logic [BYTE_W-1:0] got;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_LIMIT) begin
      @(negedge sys_clk);
      if (uart_tx_line == 1'b0) seen = 1'b1;
      else waited++;
    end
    assert (seen) else stop_with_error("no start bit from the UART echo before the timeout");
    // step from half a cycle in to mid bit
    repeat (BIT_CLKS / 2 - 1) @(negedge sys_clk);
    assert (uart_tx_line == 1'b0) else report_mismatch("echo start bit not low at mid bit");
    for (i = 0; i < BYTE_W; i++) begin
      repeat (BIT_CLKS) @(negedge sys_clk);
      got[i] = uart_tx_line;
    end
    repeat (BIT_CLKS) @(negedge sys_clk);
    assert (uart_tx_line == 1'b1) else report_mismatch("echo stop bit not high");
    assert (got == expected)
      else report_mismatch($sformatf("echo %h, expected %h", got, expected));
  endtask

  task automatic wait_frame(input int target);
    int waited;
    waited = 0;
    while (u_spi_slave_model.frame_count < target && waited < WAIT_LIMIT) begin
      @(negedge sys_clk);
      waited++;
    end
    assert (u_spi_slave_model.frame_count >= target)
      else stop_with_error($sformatf("no SPI frame %0d before the timeout", target));
  endtask

  // address byte goes out first
  task automatic check_frame(input int idx, input logic [BYTE_W-1:0] addr,
                             input logic [BYTE_W-1:0] data);
    logic [SPI_FRAME_W-1:0] expected;
    expected = {addr, data};
    assert (u_spi_slave_model.frame_q[idx] == expected)
      else report_mismatch($sformatf("frame %0d is %h, expected %h", idx,
                                     u_spi_slave_model.frame_q[idx], expected));
  endtask

  task automatic check_frame_count(input int expected);
    assert (u_spi_slave_model.frame_count == expected)
      else report_mismatch($sformatf("%0d frames recorded, expected %0d",
                                     u_spi_slave_model.frame_count, expected));
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset_state();
    int low_cycles;
    int waited;
    bit released;
    low_cycles = 0;
    waited     = 0;
    released   = 1'b0;
    apply_reset();
    // first low cycle plus the hold count
    while (!released && waited < WAIT_LIMIT) begin
      @(negedge sys_clk);
      if (slm_reset_n == 1'b1) released = 1'b1;
      else low_cycles++;
      waited++;
    end
    assert (released) else stop_with_error("display reset never released");
    assert (low_cycles == RESET_HOLD_CYCLES + 1)
      else report_mismatch($sformatf("display reset low %0d cycles, expected %0d",
                                     low_cycles, RESET_HOLD_CYCLES + 1));
    assert (spi_sen == 1'b1) else report_mismatch("spi select not high after reset");
    assert (spi_sck == 1'b0) else report_mismatch("spi clock not low after reset");
    assert (uart_tx_line == 1'b1) else report_mismatch("uart tx not idle after reset");
  endtask

  task automatic test_single_pair();
    logic [BYTE_W-1:0] addr;
    logic [BYTE_W-1:0] data;
    int                base;
    addr = 8'($random(seed));
    data = 8'($random(seed));
    base = u_spi_slave_model.frame_count;
    fork
      begin
        uart_send_byte(addr);
        uart_send_byte(data);
      end
      uart_expect_byte(~addr);
    join
    wait_frame(base + 1);
    check_frame(base, addr, data);
    check_frame_count(base + 1);
  endtask

  task automatic test_odd_byte_waits();
    logic [BYTE_W-1:0] addr;
    logic [BYTE_W-1:0] data;
    int                base;
    int                i;
    addr = 8'($random(seed));
    data = 8'($random(seed));
    base = u_spi_slave_model.frame_count;
    uart_send_byte(addr);
    // half a pair must stay parked
    for (i = 0; i < 3 * BYTE_CLKS; i++) begin
      @(negedge sys_clk);
      assert (u_spi_slave_model.frame_count == base)
        else report_mismatch($sformatf("%0d frames after a single byte, expected %0d",
                                       u_spi_slave_model.frame_count, base));
    end
    fork
      uart_send_byte(data);
      uart_expect_byte(~addr);
    join
    wait_frame(base + 1);
    check_frame(base, addr, data);
    check_frame_count(base + 1);
  endtask

  task automatic test_back_to_back();
    logic [BYTE_W-1:0] addrs [8];
    logic [BYTE_W-1:0] datas [8];
    int                base;
    int                k;
    int                ks;
    int                kr;
    for (k = 0; k < 8; k++) begin
      addrs[k] = 8'($random(seed));
      datas[k] = 8'($random(seed));
    end
    base = u_spi_slave_model.frame_count;
    // echoes overlap the following pairs
    fork
      for (ks = 0; ks < 8; ks++) begin
        uart_send_byte(addrs[ks]);
        uart_send_byte(datas[ks]);
      end
      for (kr = 0; kr < 8; kr++) begin
        uart_expect_byte(~addrs[kr]);
      end
    join
    wait_frame(base + 8);
    for (k = 0; k < 8; k++) begin
      check_frame(base + k, addrs[k], datas[k]);
    end
    check_frame_count(base + 8);
  endtask

  task automatic test_reset_clears_pairing();
    logic [BYTE_W-1:0] stale;
    logic [BYTE_W-1:0] addr;
    logic [BYTE_W-1:0] data;
    int                base;
    stale = 8'($random(seed));
    addr  = 8'($random(seed));
    data  = 8'($random(seed));
    base  = u_spi_slave_model.frame_count;
    uart_send_byte(stale);
    apply_reset();
    fork
      begin
        uart_send_byte(addr);
        uart_send_byte(data);
      end
      uart_expect_byte(~addr);
    join
    wait_frame(base + 1);
    check_frame(base, addr, data);
    check_frame_count(base + 1);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed            = 32'h2d6d_1565;
    reset_all_cmd_w = 1'b1;
    uart_rx_line    = 1'b1;
    test_reset_state();
    test_single_pair();
    test_odd_byte_waits();
    test_back_to_back();
    test_reset_clears_pairing();
    $display("TEST OK");
    $finish;
  end

  // hard stop if something hangs
  initial begin
    #1_000_000;
    $display("simulation watchdog expired before the tests finished");
    $display("TEST FAILED");
    $fatal(1, "watchdog");
  end

endmodule

// File: verilog.f
src/bridge_pkg.sv
src/reset_stretch.sv
src/uart_rx.sv
src/cmd_pairer.sv
src/spi_master.sv
src/reply_fifo.sv
src/uart_tx.sv
src/spi_bridge_top.sv
tests/spi_slave_model.sv
tests/tb_spi_bridge.sv
